// ==== logic/meas_settings.svh ====
`ifndef MEAS_SETTINGS_SVH
`define MEAS_SETTINGS_SVH

// ----------------------------------------
// bus and field widths
`define WB_DAT_W      16
`define WB_SEL_W      2
`define WB_ADR_W      32
`define REG_IDX_W     7                   // adr[7:1]

`define FRAME_LEN_W   16
`define IFG_W         32
`define IP4_W         32
`define MAC_W         48
`define IP6_W         128
`define LAT_W         24

// ----------------------------------------
// register word indices
`define REG_CTRL        7'h00
`define REG_FRAME_LEN   7'h03
`define REG_IFG_HI      7'h04
`define REG_IFG_LO      7'h05
`define REG_SRCIP_HI    7'h08
`define REG_SRCIP_LO    7'h09
`define REG_SRCMAC_0    7'h0b             // mac bits 47:32
`define REG_SRCMAC_1    7'h0c
`define REG_SRCMAC_2    7'h0d
`define REG_GWIP_HI     7'h10
`define REG_GWIP_LO     7'h11
`define REG_DSTMAC_0    7'h13             // read only
`define REG_DSTMAC_1    7'h14
`define REG_DSTMAC_2    7'h15
`define REG_DSTIP_HI    7'h16
`define REG_DSTIP_LO    7'h17
`define REG_TXPPS_HI    7'h20
`define REG_TXPPS_LO    7'h21
`define REG_TXTPUT_HI   7'h22
`define REG_TXTPUT_LO   7'h23
`define REG_TXIP_HI     7'h26
`define REG_TXIP_LO     7'h27
`define REG_RXPPS_HI    7'h28
`define REG_RXPPS_LO    7'h29
`define REG_RXTPUT_HI   7'h2a
`define REG_RXTPUT_LO   7'h2b
`define REG_RXLAT_HI    7'h2c
`define REG_RXLAT_LO    7'h2d
`define REG_RXIP_HI     7'h2e
`define REG_RXIP_LO     7'h2f
`define REG_V6SRC_BASE  7'h40             // eight words
`define REG_V6DST_BASE  7'h48             // eight words

// ----------------------------------------
// power-on defaults
`define DEF_TX_ENABLE     1'b1
`define DEF_TX_IPV6       1'b0
`define DEF_TX_FULLROUTE  1'b0
`define DEF_FRAME_LEN     16'd64
`define DEF_IFG           32'd12
`define DEF_SRC_MAC       48'h0037_7600_0100
`define DEF_GW_IP         32'h0a00_1401   // 10.0.20.1
`define DEF_SRC_IP        32'h0a00_1469   // 10.0.20.105
`define DEF_DST_IP        32'h0a00_1569   // 10.0.21.105
`define DEF_V6_SRC        128'h3776_0000_0000_0020_0000_0000_0000_0105
`define DEF_V6_DST        128'h3776_0000_0000_0021_0000_0000_0000_0105

`endif

// ==== logic/meas_pkg.sv ====
`default_nettype none

`include "meas_settings.svh"

package meas_pkg;

  // ----------------------------------------
  // wishbone
  typedef struct packed {
    logic [`WB_ADR_W-1:0] adr;
    logic [`WB_DAT_W-1:0] dat;            // master write data
    logic [`WB_SEL_W-1:0] sel;
    logic                 we;
    logic                 cyc;
    logic                 stb;
  } wb_req_t;

  typedef struct packed {
    logic [`WB_DAT_W-1:0] dat;            // readback, bus byte order
    logic                 ack;
  } wb_rsp_t;

  // write request toward the register bank, field byte order
  typedef struct packed {
    logic                  valid;
    logic [`REG_IDX_W-1:0] idx;
    logic [`WB_DAT_W-1:0]  dat;
    logic [`WB_SEL_W-1:0]  be;            // be[0] is slice bits 7:0
  } reg_wr_t;

  // ----------------------------------------
  // traffic generator configuration
  typedef struct packed {
    logic                    enable;
    logic                    ipv6;
    logic                    fullroute;
    logic [`FRAME_LEN_W-1:0] frame_len;
    logic [`IFG_W-1:0]       ifg;
    logic [`IP4_W-1:0]       src_ip;
    logic [`IP4_W-1:0]       gw_ip;
    logic [`IP4_W-1:0]       dst_ip;
    logic [`MAC_W-1:0]       src_mac;
    logic [`IP6_W-1:0]       v6_src;
    logic [`IP6_W-1:0]       v6_dst;
  } tx_cfg_t;

  // results reported by the measurement engine
  typedef struct packed {
    logic [`MAC_W-1:0] dst_mac;           // resolved by arp
    logic [31:0]       tx_pps;
    logic [31:0]       tx_tput;
    logic [`IP4_W-1:0] tx_ip;
    logic [31:0]       rx_pps;
    logic [31:0]       rx_tput;
    logic [`IP4_W-1:0] rx_ip;
    logic [`LAT_W-1:0] rx_lat;
  } meas_status_t;

endpackage

`default_nettype wire

// ==== logic/wb_slave_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "meas_settings.svh"

module wb_slave_port
  import meas_pkg::*;
(
  input  wire logic                  clk_125,
  input  wire logic                  core_rst_n,
  input  wire wb_req_t               wb_req_i,
  output wb_rsp_t                    wb_rsp_o,
  output logic [`REG_IDX_W-1:0]      rd_idx_o,
  input  wire logic [`WB_DAT_W-1:0]  rd_dat_i,
  output reg_wr_t                    wr_o
);

  logic                 acc;
  logic                 rd_stb;
  logic                 ack_q;
  logic [`WB_DAT_W-1:0] dat_q;

  assign acc    = wb_req_i.cyc & wb_req_i.stb;
  assign rd_stb = acc & ~wb_req_i.we;

  // ----------------------------------------
  // ack and readback
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      ack_q <= 1'b0;
      dat_q <= '0;
    end else begin
      ack_q <= acc & ~ack_q;              // alternates while stb held
      if (rd_stb) begin
        dat_q <= rd_dat_i;
      end
    end
  end

  assign wb_rsp_o = '{dat: dat_q, ack: ack_q};

  assign rd_idx_o = wb_req_i.adr[`REG_IDX_W:1];

  // ----------------------------------------
  // write request
  always_comb begin
    wr_o.valid = acc & wb_req_i.we;
    wr_o.idx   = wb_req_i.adr[`REG_IDX_W:1];
    wr_o.dat   = {wb_req_i.dat[7:0], wb_req_i.dat[15:8]};  // bus halfword is byte swapped
    wr_o.be[0] = wb_req_i.sel[0];         // steers bus 15:8, slice 7:0
    wr_o.be[1] = wb_req_i.sel[1];         // steers bus 7:0, slice 15:8
  end

endmodule

`default_nettype wire

// ==== logic/tx_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "meas_settings.svh"

module tx_cfg_regs
  import meas_pkg::*;
(
  input  wire logic    clk_125,
  input  wire logic    core_rst_n,
  input  wire reg_wr_t wr_i,
  output tx_cfg_t      cfg_o
);

  localparam logic [`REG_IDX_W-1:0] V6_SRC_BASE = `REG_V6SRC_BASE;
  localparam logic [`REG_IDX_W-1:0] V6_DST_BASE = `REG_V6DST_BASE;

  localparam tx_cfg_t DEF_CFG = '{
    enable:    `DEF_TX_ENABLE,
    ipv6:      `DEF_TX_IPV6,
    fullroute: `DEF_TX_FULLROUTE,
    frame_len: `DEF_FRAME_LEN,
    ifg:       `DEF_IFG,
    src_ip:    `DEF_SRC_IP,
    gw_ip:     `DEF_GW_IP,
    dst_ip:    `DEF_DST_IP,
    src_mac:   `DEF_SRC_MAC,
    v6_src:    `DEF_V6_SRC,
    v6_dst:    `DEF_V6_DST
  };

  tx_cfg_t    cfg_q;
  logic       hit_v6_src;
  logic       hit_v6_dst;
  logic [6:0] v6_ofs;

  // byte-enabled update of one halfword slice
  function automatic logic [15:0] merge_hw(input logic [15:0] cur, input reg_wr_t wr);
    logic [15:0] res;
    res = cur;
    if (wr.be[0]) begin
      res[7:0] = wr.dat[7:0];
    end
    if (wr.be[1]) begin
      res[15:8] = wr.dat[15:8];
    end
    return res;
  endfunction

  assign hit_v6_src = (wr_i.idx[`REG_IDX_W-1:3] == V6_SRC_BASE[`REG_IDX_W-1:3]);
  assign hit_v6_dst = (wr_i.idx[`REG_IDX_W-1:3] == V6_DST_BASE[`REG_IDX_W-1:3]);
  assign v6_ofs     = {~wr_i.idx[2:0], 4'b0000};  // lowest word is the top slice

  // ----------------------------------------
  // register bank
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      cfg_q <= DEF_CFG;
    end else if (wr_i.valid) begin
      if (hit_v6_src) begin
        cfg_q.v6_src[v6_ofs +: 16] <= merge_hw(cfg_q.v6_src[v6_ofs +: 16], wr_i);
      end else if (hit_v6_dst) begin
        cfg_q.v6_dst[v6_ofs +: 16] <= merge_hw(cfg_q.v6_dst[v6_ofs +: 16], wr_i);
      end else begin
        case (wr_i.idx)
          `REG_CTRL: begin
            if (wr_i.be[1]) begin
              cfg_q.enable    <= wr_i.dat[15];  // bus bit 7
              cfg_q.ipv6      <= wr_i.dat[14];  // bus bit 6
              cfg_q.fullroute <= wr_i.dat[8];   // bus bit 0
            end
          end
          `REG_FRAME_LEN: begin
            cfg_q.frame_len <= merge_hw(cfg_q.frame_len, wr_i);
          end
          `REG_IFG_HI: begin
            cfg_q.ifg[31:16] <= merge_hw(cfg_q.ifg[31:16], wr_i);
          end
          `REG_IFG_LO: begin
            cfg_q.ifg[15:0] <= merge_hw(cfg_q.ifg[15:0], wr_i);
          end
          `REG_SRCIP_HI: begin
            cfg_q.src_ip[31:16] <= merge_hw(cfg_q.src_ip[31:16], wr_i);
          end
          `REG_SRCIP_LO: begin
            cfg_q.src_ip[15:0] <= merge_hw(cfg_q.src_ip[15:0], wr_i);
          end
          `REG_SRCMAC_0: begin
            cfg_q.src_mac[47:32] <= merge_hw(cfg_q.src_mac[47:32], wr_i);
          end
          `REG_SRCMAC_1: begin
            cfg_q.src_mac[31:16] <= merge_hw(cfg_q.src_mac[31:16], wr_i);
          end
          `REG_SRCMAC_2: begin
            cfg_q.src_mac[15:0] <= merge_hw(cfg_q.src_mac[15:0], wr_i);
          end
          `REG_GWIP_HI: begin
            cfg_q.gw_ip[31:16] <= merge_hw(cfg_q.gw_ip[31:16], wr_i);
          end
          `REG_GWIP_LO: begin
            cfg_q.gw_ip[15:0] <= merge_hw(cfg_q.gw_ip[15:0], wr_i);
          end
          `REG_DSTIP_HI: begin
            cfg_q.dst_ip[31:16] <= merge_hw(cfg_q.dst_ip[31:16], wr_i);
          end
          `REG_DSTIP_LO: begin
            cfg_q.dst_ip[15:0] <= merge_hw(cfg_q.dst_ip[15:0], wr_i);
          end
          default: begin
            // status, dst mac and unmapped words are read only
          end
        endcase
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// ==== logic/reg_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "meas_settings.svh"

module reg_read_mux
  import meas_pkg::*;
(
  input  wire logic [`REG_IDX_W-1:0] rd_idx_i,
  input  wire tx_cfg_t               cfg_i,
  input  wire meas_status_t          status_i,
  output logic [`WB_DAT_W-1:0]       rd_dat_o
);

  localparam logic [`REG_IDX_W-1:0] V6_SRC_BASE = `REG_V6SRC_BASE;
  localparam logic [`REG_IDX_W-1:0] V6_DST_BASE = `REG_V6DST_BASE;

  logic       hit_v6_src;
  logic       hit_v6_dst;
  logic [6:0] v6_ofs;

  // field slice to bus byte order
  function automatic logic [15:0] to_bus(input logic [15:0] slice);
    return {slice[7:0], slice[15:8]};
  endfunction

  assign hit_v6_src = (rd_idx_i[`REG_IDX_W-1:3] == V6_SRC_BASE[`REG_IDX_W-1:3]);
  assign hit_v6_dst = (rd_idx_i[`REG_IDX_W-1:3] == V6_DST_BASE[`REG_IDX_W-1:3]);
  assign v6_ofs     = {~rd_idx_i[2:0], 4'b0000};

  always_comb begin
    rd_dat_o = '0;
    if (hit_v6_src) begin
      rd_dat_o = to_bus(cfg_i.v6_src[v6_ofs +: 16]);
    end else if (hit_v6_dst) begin
      rd_dat_o = to_bus(cfg_i.v6_dst[v6_ofs +: 16]);
    end else begin
      case (rd_idx_i)
        // ----------------------------------------
        // configuration
        `REG_CTRL: begin
          rd_dat_o = {8'h00, cfg_i.enable, cfg_i.ipv6, 5'b0_0000, cfg_i.fullroute};
        end
        `REG_FRAME_LEN: rd_dat_o = to_bus(cfg_i.frame_len);
        `REG_IFG_HI:    rd_dat_o = to_bus(cfg_i.ifg[31:16]);
        `REG_IFG_LO:    rd_dat_o = to_bus(cfg_i.ifg[15:0]);
        `REG_SRCIP_HI:  rd_dat_o = to_bus(cfg_i.src_ip[31:16]);
        `REG_SRCIP_LO:  rd_dat_o = to_bus(cfg_i.src_ip[15:0]);
        `REG_SRCMAC_0:  rd_dat_o = to_bus(cfg_i.src_mac[47:32]);
        `REG_SRCMAC_1:  rd_dat_o = to_bus(cfg_i.src_mac[31:16]);
        `REG_SRCMAC_2:  rd_dat_o = to_bus(cfg_i.src_mac[15:0]);
        `REG_GWIP_HI:   rd_dat_o = to_bus(cfg_i.gw_ip[31:16]);
        `REG_GWIP_LO:   rd_dat_o = to_bus(cfg_i.gw_ip[15:0]);
        `REG_DSTIP_HI:  rd_dat_o = to_bus(cfg_i.dst_ip[31:16]);
        `REG_DSTIP_LO:  rd_dat_o = to_bus(cfg_i.dst_ip[15:0]);
        // ----------------------------------------
        // engine results
        `REG_DSTMAC_0:  rd_dat_o = to_bus(status_i.dst_mac[47:32]);
        `REG_DSTMAC_1:  rd_dat_o = to_bus(status_i.dst_mac[31:16]);
        `REG_DSTMAC_2:  rd_dat_o = to_bus(status_i.dst_mac[15:0]);
        `REG_TXPPS_HI:  rd_dat_o = to_bus(status_i.tx_pps[31:16]);
        `REG_TXPPS_LO:  rd_dat_o = to_bus(status_i.tx_pps[15:0]);
        `REG_TXTPUT_HI: rd_dat_o = to_bus(status_i.tx_tput[31:16]);
        `REG_TXTPUT_LO: rd_dat_o = to_bus(status_i.tx_tput[15:0]);
        `REG_TXIP_HI:   rd_dat_o = to_bus(status_i.tx_ip[31:16]);
        `REG_TXIP_LO:   rd_dat_o = to_bus(status_i.tx_ip[15:0]);
        `REG_RXPPS_HI:  rd_dat_o = to_bus(status_i.rx_pps[31:16]);
        `REG_RXPPS_LO:  rd_dat_o = to_bus(status_i.rx_pps[15:0]);
        `REG_RXTPUT_HI: rd_dat_o = to_bus(status_i.rx_tput[31:16]);
        `REG_RXTPUT_LO: rd_dat_o = to_bus(status_i.rx_tput[15:0]);
        `REG_RXLAT_HI:  rd_dat_o = {status_i.rx_lat[23:16], 8'h00};  // top byte only
        `REG_RXLAT_LO:  rd_dat_o = to_bus(status_i.rx_lat[15:0]);
        `REG_RXIP_HI:   rd_dat_o = to_bus(status_i.rx_ip[31:16]);
        `REG_RXIP_LO:   rd_dat_o = to_bus(status_i.rx_ip[15:0]);
        default:        rd_dat_o = '0;    // unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/meas_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "meas_settings.svh"

module meas_ctrl_top
  import meas_pkg::*;
(
  input  wire logic         clk_125,
  input  wire logic         core_rst_n,
  input  wire wb_req_t      wb_req_i,
  output wire wb_rsp_t      wb_rsp_o,
  input  wire meas_status_t status_i,
  output wire tx_cfg_t      cfg_o
);

  logic [`REG_IDX_W-1:0] rd_idx;
  logic [`WB_DAT_W-1:0]  rd_dat;
  reg_wr_t               reg_wr;
  tx_cfg_t               cfg;

  wb_slave_port wb_slave_port_inst (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .rd_idx_o   (rd_idx),
    .rd_dat_i   (rd_dat),
    .wr_o       (reg_wr)
  );

  tx_cfg_regs tx_cfg_regs_inst (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .wr_i       (reg_wr),
    .cfg_o      (cfg)
  );

  reg_read_mux reg_read_mux_inst (
    .rd_idx_i   (rd_idx),
    .cfg_i      (cfg),                    // readback of live config
    .status_i   (status_i),
    .rd_dat_o   (rd_dat)
  );

  assign cfg_o = cfg;

endmodule

`default_nettype wire

// ==== verification/meas_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "meas_settings.svh"

module meas_ctrl_tb
  import meas_pkg::*;
();

  localparam int ACK_TIMEOUT = 16;

  localparam tx_cfg_t DEF_CFG = '{
    enable:    `DEF_TX_ENABLE,
    ipv6:      `DEF_TX_IPV6,
    fullroute: `DEF_TX_FULLROUTE,
    frame_len: `DEF_FRAME_LEN,
    ifg:       `DEF_IFG,
    src_ip:    `DEF_SRC_IP,
    gw_ip:     `DEF_GW_IP,
    dst_ip:    `DEF_DST_IP,
    src_mac:   `DEF_SRC_MAC,
    v6_src:    `DEF_V6_SRC,
    v6_dst:    `DEF_V6_DST
  };

  logic         clk_125;
  logic         core_rst_n;
  wb_req_t      req;
  wb_rsp_t      rsp;
  meas_status_t status;
  tx_cfg_t      cfg;
  tx_cfg_t      exp_cfg;
  int           err_cnt;
  int           timeout_cnt;

  meas_ctrl_top meas_ctrl_top_inst (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .wb_req_i   (req),
    .wb_rsp_o   (rsp),
    .status_i   (status),
    .cfg_o      (cfg)
  );

  initial begin
    clk_125 = 1'b0;
    forever #4 clk_125 = ~clk_125;
  end

  // ----------------------------------------
  // reference model
  function automatic logic [15:0] bus_order(input logic [15:0] s);
    return {s[7:0], s[15:8]};
  endfunction

  // lsb of the slice inside the flat tx_cfg_t vector, -1 if not a plain field
  function automatic int slice_lsb(input logic [6:0] idx);
    if (idx[6:3] == 4'b1000) return 128 + (7 - int'(idx[2:0])) * 16;  // v6 src
    if (idx[6:3] == 4'b1001) return (7 - int'(idx[2:0])) * 16;        // v6 dst
    case (idx)
      `REG_FRAME_LEN: return 432;
      `REG_IFG_HI:    return 416;
      `REG_IFG_LO:    return 400;
      `REG_SRCIP_HI:  return 384;
      `REG_SRCIP_LO:  return 368;
      `REG_GWIP_HI:   return 352;
      `REG_GWIP_LO:   return 336;
      `REG_DSTIP_HI:  return 320;
      `REG_DSTIP_LO:  return 304;
      `REG_SRCMAC_0:  return 288;
      `REG_SRCMAC_1:  return 272;
      `REG_SRCMAC_2:  return 256;
      default:        return -1;
    endcase
  endfunction

  function automatic bit is_writable(input logic [6:0] idx);
    return (idx == `REG_CTRL) || (slice_lsb(idx) >= 0);
  endfunction

  function automatic logic [15:0] status_word(input meas_status_t st, input logic [6:0] idx);
    case (idx)
      `REG_DSTMAC_0:  return bus_order(st.dst_mac[47:32]);
      `REG_DSTMAC_1:  return bus_order(st.dst_mac[31:16]);
      `REG_DSTMAC_2:  return bus_order(st.dst_mac[15:0]);
      `REG_TXPPS_HI:  return bus_order(st.tx_pps[31:16]);
      `REG_TXPPS_LO:  return bus_order(st.tx_pps[15:0]);
      `REG_TXTPUT_HI: return bus_order(st.tx_tput[31:16]);
      `REG_TXTPUT_LO: return bus_order(st.tx_tput[15:0]);
      `REG_TXIP_HI:   return bus_order(st.tx_ip[31:16]);
      `REG_TXIP_LO:   return bus_order(st.tx_ip[15:0]);
      `REG_RXPPS_HI:  return bus_order(st.rx_pps[31:16]);
      `REG_RXPPS_LO:  return bus_order(st.rx_pps[15:0]);
      `REG_RXTPUT_HI: return bus_order(st.rx_tput[31:16]);
      `REG_RXTPUT_LO: return bus_order(st.rx_tput[15:0]);
      `REG_RXLAT_HI:  return {st.rx_lat[23:16], 8'h00};  // top latency byte alone
      `REG_RXLAT_LO:  return bus_order(st.rx_lat[15:0]);
      `REG_RXIP_HI:   return bus_order(st.rx_ip[31:16]);
      `REG_RXIP_LO:   return bus_order(st.rx_ip[15:0]);
      default:        return 16'h0000;
    endcase
  endfunction

  function automatic logic [15:0] exp_word(input logic [6:0] idx);
    logic [15:0] s;
    int          lsb;
    lsb = slice_lsb(idx);
    if (idx == `REG_CTRL) begin
      return {8'h00, exp_cfg.enable, exp_cfg.ipv6, 5'b0_0000, exp_cfg.fullroute};
    end
    if (lsb >= 0) begin
      s = exp_cfg[lsb +: 16];
      return bus_order(s);
    end
    return status_word(status, idx);
  endfunction

  function automatic void model_write(input logic [6:0] idx, input logic [15:0] dat,
                                      input logic [1:0] sel);
    int lsb;
    lsb = slice_lsb(idx);
    if (idx == `REG_CTRL) begin
      if (sel[1]) begin
        exp_cfg.enable    = dat[7];
        exp_cfg.ipv6      = dat[6];
        exp_cfg.fullroute = dat[0];
      end
    end else if (lsb >= 0) begin
      if (sel[0]) exp_cfg[lsb +: 8] = dat[15:8];
      if (sel[1]) exp_cfg[lsb + 8 +: 8] = dat[7:0];
    end
  endfunction

  function automatic meas_status_t rand_status();
    logic [287:0] r;
    for (int i = 0; i < 9; i++) begin
      r[i*32 +: 32] = $urandom();
    end
    return meas_status_t'(r[$bits(meas_status_t)-1:0]);
  endfunction

  // ----------------------------------------
  // compare tasks
  task automatic check_dat(input wb_rsp_t got, input logic [15:0] exp, input string what);
    if (got.dat !== exp) begin
      err_cnt++;
      $display("FAILED %0t: %s read 0x%04h expected 0x%04h", $time, what, got.dat, exp);
    end
  endtask

  task automatic check_cfg(input tx_cfg_t got, input tx_cfg_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %0t: %s cfg_o mismatch", $time, what);
      $display("  got      %h", got);
      $display("  expected %h", exp);
    end
  endtask

  task automatic check_ack(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %0t: %s ack %b expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // bus tasks, inputs change on the falling edge
  task automatic bus_access(input logic we, input logic [6:0] idx, input logic [15:0] dat,
                            input logic [1:0] sel, output wb_rsp_t got);
    int n;
    @(negedge clk_125);
    req = '{adr: {24'h0, idx, 1'b0}, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    n = 0;
    do begin
      @(negedge clk_125);
      n++;
    end while (!rsp.ack && n < ACK_TIMEOUT);
    got = rsp;
    if (!rsp.ack) begin
      timeout_cnt++;
      $display("no ack from word 0x%02h within %0d cycles", idx, ACK_TIMEOUT);
    end
    req = '0;                             // stb drops right after ack
  endtask

  task automatic wb_write(input logic [6:0] idx, input logic [15:0] dat, input logic [1:0] sel);
    wb_rsp_t unused;
    bus_access(1'b1, idx, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [6:0] idx, output wb_rsp_t got);
    bus_access(1'b0, idx, 16'h0000, 2'b11, got);
  endtask

  task automatic write_and_model(input logic [6:0] idx, input logic [15:0] dat,
                                 input logic [1:0] sel);
    wb_write(idx, dat, sel);
    model_write(idx, dat, sel);
  endtask

  task automatic verify_all(input string tag);
    wb_rsp_t got;
    check_cfg(cfg, exp_cfg, tag);
    for (int i = 0; i < 128; i++) begin
      wb_read(7'(i), got);
      check_dat(got, exp_word(7'(i)), $sformatf("%s word 0x%02h", tag, i));
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_125);
    req        = '0;
    core_rst_n = 1'b0;
    repeat (2) @(negedge clk_125);
    core_rst_n = 1'b1;
    exp_cfg    = DEF_CFG;
  endtask

  // ----------------------------------------
  // directed tests
  task automatic test_reset_defaults();
    verify_all("reset");
  endtask

  task automatic test_full_writes();
    for (int i = 0; i < 128; i++) begin
      if (is_writable(7'(i))) write_and_model(7'(i), 16'($urandom()), 2'b11);
    end
    verify_all("full");
  endtask

  task automatic test_byte_lanes();
    for (int i = 0; i < 128; i++) begin
      if (is_writable(7'(i))) begin
        write_and_model(7'(i), 16'($urandom()), 2'b10);  // upper lane first
        write_and_model(7'(i), 16'($urandom()), 2'b01);
      end
    end
    verify_all("lanes");
  endtask

  task automatic test_status_unmapped();
    @(negedge clk_125);
    status = rand_status();
    for (int i = 0; i < 128; i++) begin
      if (!is_writable(7'(i))) write_and_model(7'(i), 16'($urandom()), 2'b11);  // ignored
    end
    verify_all("status");
  endtask

  task automatic test_handshake();
    wb_rsp_t got;
    write_and_model(`REG_FRAME_LEN, 16'hffff, 2'b11);
    wb_read(`REG_FRAME_LEN, got);
    check_dat(got, exp_word(`REG_FRAME_LEN), "readback before reset");
    apply_reset();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_125);
      check_ack(rsp.ack, 1'b0, "idle after reset");
    end
    check_dat(rsp, 16'h0000, "read data after reset");
    check_cfg(cfg, exp_cfg, "handshake reset");
    req = '{adr: {24'h0, `REG_FRAME_LEN, 1'b0}, dat: 16'h0, sel: 2'b11,
            we: 1'b0, cyc: 1'b1, stb: 1'b1};
    for (int i = 1; i <= 6; i++) begin
      @(negedge clk_125);
      check_ack(rsp.ack, 1'(i % 2), $sformatf("held strobe cycle %0d", i));
      if (rsp.ack) check_dat(rsp, exp_word(`REG_FRAME_LEN), "held strobe read");
    end
    req = '0;
    @(negedge clk_125);
    check_ack(rsp.ack, 1'b0, "strobe released");
  endtask

  initial begin
    void'($urandom(32'h5599_f052));
    err_cnt     = 0;
    timeout_cnt = 0;
    req         = '0;
    status      = '0;
    core_rst_n  = 1'b0;
    exp_cfg     = DEF_CFG;
    apply_reset();
    test_reset_defaults();
    test_full_writes();
    test_byte_lanes();
    test_status_unmapped();
    test_handshake();
    $display("mismatches: %0d, ack timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/meas_pkg.sv
logic/wb_slave_port.sv
logic/tx_cfg_regs.sv
logic/reg_read_mux.sv
logic/meas_ctrl_top.sv
verification/meas_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: meas_ctrl

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/meas_pkg.sv
      - logic/wb_slave_port.sv
      - logic/tx_cfg_regs.sv
      - logic/reg_read_mux.sv
      - logic/meas_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/meas_ctrl_tb.sv
